// File: source/game_pkg.sv
`default_nettype none

package game_pkg;

    // Screen coordinate of a sprite's top left corner, in pixels
    typedef logic [9:0] coord_t;

    // Signed step that is added to a coordinate on every move
    typedef logic signed [3:0] velocity_t;

    // Visible area of the screen
    localparam int unsigned SCREEN_WIDTH  = 640;
    localparam int unsigned SCREEN_HEIGHT = 480;

    // Both sprites are squares of this size
    localparam int unsigned SPRITE_SIZE = 16;

    // Phases of one round of the game
    typedef enum logic [1:0]
    {
        STATE_START,
        STATE_AIM,
        STATE_SHOOT,
        STATE_END
    } game_state_t;

endpackage

`default_nettype wire

// File: source/sprite_mover.sv
`timescale 1ns/1ns
`default_nettype none

module sprite_mover
#(
    parameter int                  STEP_PERIOD = 4,
    parameter game_pkg::coord_t    X0          = '0,
    parameter game_pkg::coord_t    Y0          = '0,
    parameter game_pkg::velocity_t DX0         = '0,
    parameter game_pkg::velocity_t DY0         = '0
)
(
    input  logic             clk,
    input  logic             reset,

    input  logic             write_xy,
    input  logic             write_dxy,
    input  logic             enable_update,

    output game_pkg::coord_t x,
    output game_pkg::coord_t y,
    output logic             within_screen
);

    localparam int STEP_W  = $clog2(STEP_PERIOD + 1);
    localparam int COORD_W = $bits(game_pkg::coord_t);

    logic [STEP_W-1:0]   step_count;
    logic                step_now;

    game_pkg::velocity_t dx;
    game_pkg::velocity_t dy;

    // One bit wider than a coordinate, so that the far edge cannot wrap
    logic [COORD_W:0]    x_right;
    logic [COORD_W:0]    y_bottom;

    assign step_now = enable_update && (step_count == STEP_W'(STEP_PERIOD - 1));

    // Pacing counter restarts whenever a new start position is loaded
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            step_count <= '0;
        else if (write_xy || step_now)
            step_count <= '0;
        else if (enable_update)
            step_count <= step_count + 1'b1;
    end

    // A velocity load wins over the clear that comes with a position load
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            dx <= '0;
            dy <= '0;
        end
        else if (write_dxy)
        begin
            dx <= DX0;
            dy <= DY0;
        end
        else if (write_xy)
        begin
            dx <= '0;
            dy <= '0;
        end
    end

    // The cast sign-extends the velocity, so a negative step wraps modulo the width
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            x <= X0;
            y <= Y0;
        end
        else if (write_xy)
        begin
            x <= X0;
            y <= Y0;
        end
        else if (step_now)
        begin
            x <= x + game_pkg::coord_t'(dx);
            y <= y + game_pkg::coord_t'(dy);
        end
    end

    // A position that wrapped below zero lands near the top of the range and fails here
    assign x_right  = {1'b0, x} + (COORD_W + 1)'(game_pkg::SPRITE_SIZE);
    assign y_bottom = {1'b0, y} + (COORD_W + 1)'(game_pkg::SPRITE_SIZE);

    assign within_screen = (x_right  <= (COORD_W + 1)'(game_pkg::SCREEN_WIDTH))
                        && (y_bottom <= (COORD_W + 1)'(game_pkg::SCREEN_HEIGHT));

endmodule

`default_nettype wire

// File: source/sprite_collision.sv
`timescale 1ns/1ns
`default_nettype none

module sprite_collision
(
    input  game_pkg::coord_t target_x,
    input  game_pkg::coord_t target_y,
    input  game_pkg::coord_t torpedo_x,
    input  game_pkg::coord_t torpedo_y,

    output logic             collision
);

    localparam int COORD_W = $bits(game_pkg::coord_t);

    // Far edges are kept one bit wider so that a sprite near the top of the range does not wrap
    logic [COORD_W:0] target_x_end;
    logic [COORD_W:0] target_y_end;
    logic [COORD_W:0] torpedo_x_end;
    logic [COORD_W:0] torpedo_y_end;

    logic             overlap_x;
    logic             overlap_y;

    assign target_x_end  = {1'b0, target_x}  + (COORD_W + 1)'(game_pkg::SPRITE_SIZE);
    assign target_y_end  = {1'b0, target_y}  + (COORD_W + 1)'(game_pkg::SPRITE_SIZE);
    assign torpedo_x_end = {1'b0, torpedo_x} + (COORD_W + 1)'(game_pkg::SPRITE_SIZE);
    assign torpedo_y_end = {1'b0, torpedo_y} + (COORD_W + 1)'(game_pkg::SPRITE_SIZE);

    // Two intervals overlap when each one starts before the other one ends
    assign overlap_x = ({1'b0, target_x} < torpedo_x_end) && ({1'b0, torpedo_x} < target_x_end);
    assign overlap_y = ({1'b0, target_y} < torpedo_y_end) && ({1'b0, torpedo_y} < target_y_end);

    assign collision = overlap_x && overlap_y;

endmodule

`default_nettype wire

// File: source/end_of_game_timer.sv
`timescale 1ns/1ns
`default_nettype none

module end_of_game_timer
#(
    parameter int END_HOLD_CYCLES = 64
)
(
    input  logic clk,
    input  logic reset,

    input  logic start,
    output logic running
);

    localparam int COUNT_W = $clog2(END_HOLD_CYCLES + 1);

    logic [COUNT_W-1:0] count;

    // A new start pulse reloads the counter even in the middle of a hold
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            count <= '0;
        else if (start)
            count <= COUNT_W'(END_HOLD_CYCLES);
        else if (count != '0)
            count <= count - 1'b1;
    end

    assign running = (count != '0);

endmodule

`default_nettype wire

// File: source/game_master_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module game_master_fsm
(
    input  logic clk,
    input  logic reset,

    input  logic key,

    input  logic target_within_screen,
    input  logic torpedo_within_screen,
    input  logic collision,
    input  logic end_of_game_timer_running,

    output logic target_write_xy,
    output logic torpedo_write_xy,
    output logic target_write_dxy,
    output logic torpedo_write_dxy,
    output logic target_enable_update,
    output logic torpedo_enable_update,
    output logic end_of_game_timer_start,
    output logic game_won
);

    game_pkg::game_state_t state;
    game_pkg::game_state_t d_state;

    logic d_target_write_xy;
    logic d_torpedo_write_xy;
    logic d_target_write_dxy;
    logic d_torpedo_write_dxy;
    logic d_target_enable_update;
    logic d_torpedo_enable_update;
    logic d_end_of_game_timer_start;
    logic d_game_won;

    logic end_of_game;

    // A round ends on a hit or as soon as either sprite leaves the screen
    assign end_of_game = !target_within_screen || !torpedo_within_screen || collision;

    always_comb
    begin
        d_state                   = state;

        d_target_write_xy         = 1'b0;
        d_torpedo_write_xy        = 1'b0;
        d_target_write_dxy        = 1'b0;
        d_torpedo_write_dxy       = 1'b0;
        d_target_enable_update    = 1'b0;
        d_torpedo_enable_update   = 1'b0;
        d_end_of_game_timer_start = 1'b0;
        d_game_won                = game_won;

        case (state)
            game_pkg::STATE_START:
            begin
                // The torpedo velocity is cleared by its position load
                d_target_write_xy  = 1'b1;
                d_torpedo_write_xy = 1'b1;
                d_target_write_dxy = 1'b1;
                d_game_won         = 1'b0;

                d_state = game_pkg::STATE_AIM;
            end

            game_pkg::STATE_AIM:
            begin
                d_target_enable_update = 1'b1;

                // While the start load is still on its way the sprites may sit
                // where the last round left them, so the end test waits a cycle
                if (key)
                begin
                    d_state = game_pkg::STATE_SHOOT;
                end
                else if (end_of_game && !target_write_xy)
                begin
                    d_end_of_game_timer_start = 1'b1;
                    d_state = game_pkg::STATE_END;
                end
            end

            game_pkg::STATE_SHOOT:
            begin
                d_torpedo_write_dxy     = 1'b1;
                d_target_enable_update  = 1'b1;
                d_torpedo_enable_update = 1'b1;

                if (collision)
                    d_game_won = 1'b1;

                if (end_of_game)
                begin
                    d_end_of_game_timer_start = 1'b1;
                    d_state = game_pkg::STATE_END;
                end
            end

            game_pkg::STATE_END:
            begin
                // A hit seen together with the exit still counts as a win
                if (collision)
                    d_game_won = 1'b1;

                // The timer only reports running one cycle after its start pulse
                if (!end_of_game_timer_running && !end_of_game_timer_start)
                    d_state = game_pkg::STATE_START;
            end

            default:
            begin
                d_state = game_pkg::STATE_START;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state                   <= game_pkg::STATE_START;

            target_write_xy         <= 1'b0;
            torpedo_write_xy        <= 1'b0;
            target_write_dxy        <= 1'b0;
            torpedo_write_dxy       <= 1'b0;
            target_enable_update    <= 1'b0;
            torpedo_enable_update   <= 1'b0;
            end_of_game_timer_start <= 1'b0;
            game_won                <= 1'b0;
        end
        else
        begin
            state                   <= d_state;

            target_write_xy         <= d_target_write_xy;
            torpedo_write_xy        <= d_torpedo_write_xy;
            target_write_dxy        <= d_target_write_dxy;
            torpedo_write_dxy       <= d_torpedo_write_dxy;
            target_enable_update    <= d_target_enable_update;
            torpedo_enable_update   <= d_torpedo_enable_update;
            end_of_game_timer_start <= d_end_of_game_timer_start;
            game_won                <= d_game_won;
        end
    end

endmodule

`default_nettype wire

// File: source/game_top.sv
`timescale 1ns/1ns
`default_nettype none

module game_top
#(
    parameter int                  STEP_PERIOD     = 4,
    parameter int                  END_HOLD_CYCLES = 64,

    parameter game_pkg::coord_t    TARGET_X0       = 10'd0,
    parameter game_pkg::coord_t    TARGET_Y0       = 10'd100,
    parameter game_pkg::velocity_t TARGET_DX       = 4'sd1,
    parameter game_pkg::velocity_t TARGET_DY       = 4'sd0,

    parameter game_pkg::coord_t    TORPEDO_X0      = 10'd312,
    parameter game_pkg::coord_t    TORPEDO_Y0      = 10'd440,
    parameter game_pkg::velocity_t TORPEDO_DY      = -4'sd4
)
(
    input  logic             clk,
    input  logic             reset,

    input  logic             key,

    output game_pkg::coord_t target_x,
    output game_pkg::coord_t target_y,
    output game_pkg::coord_t torpedo_x,
    output game_pkg::coord_t torpedo_y,

    output logic             game_won,
    output logic             game_over
);

    logic target_write_xy;
    logic torpedo_write_xy;
    logic target_write_dxy;
    logic torpedo_write_dxy;
    logic target_enable_update;
    logic torpedo_enable_update;

    logic target_within_screen;
    logic torpedo_within_screen;
    logic collision;

    logic end_of_game_timer_start;

    game_master_fsm fsm0
    (
        .clk                       (clk),
        .reset                     (reset),
        .key                       (key),
        .target_within_screen      (target_within_screen),
        .torpedo_within_screen     (torpedo_within_screen),
        .collision                 (collision),
        .end_of_game_timer_running (game_over),
        .target_write_xy           (target_write_xy),
        .torpedo_write_xy          (torpedo_write_xy),
        .target_write_dxy          (target_write_dxy),
        .torpedo_write_dxy         (torpedo_write_dxy),
        .target_enable_update      (target_enable_update),
        .torpedo_enable_update     (torpedo_enable_update),
        .end_of_game_timer_start   (end_of_game_timer_start),
        .game_won                  (game_won)
    );

    sprite_mover
    #(
        .STEP_PERIOD (STEP_PERIOD),
        .X0          (TARGET_X0),
        .Y0          (TARGET_Y0),
        .DX0         (TARGET_DX),
        .DY0         (TARGET_DY)
    )
    target_mover
    (
        .clk           (clk),
        .reset         (reset),
        .write_xy      (target_write_xy),
        .write_dxy     (target_write_dxy),
        .enable_update (target_enable_update),
        .x             (target_x),
        .y             (target_y),
        .within_screen (target_within_screen)
    );

    // The torpedo only ever flies straight up
    sprite_mover
    #(
        .STEP_PERIOD (STEP_PERIOD),
        .X0          (TORPEDO_X0),
        .Y0          (TORPEDO_Y0),
        .DX0         (4'sd0),
        .DY0         (TORPEDO_DY)
    )
    torpedo_mover
    (
        .clk           (clk),
        .reset         (reset),
        .write_xy      (torpedo_write_xy),
        .write_dxy     (torpedo_write_dxy),
        .enable_update (torpedo_enable_update),
        .x             (torpedo_x),
        .y             (torpedo_y),
        .within_screen (torpedo_within_screen)
    );

    sprite_collision collision0
    (
        .target_x  (target_x),
        .target_y  (target_y),
        .torpedo_x (torpedo_x),
        .torpedo_y (torpedo_y),
        .collision (collision)
    );

    end_of_game_timer #(.END_HOLD_CYCLES (END_HOLD_CYCLES)) timer0
    (
        .clk     (clk),
        .reset   (reset),
        .start   (end_of_game_timer_start),
        .running (game_over)
    );

endmodule

`default_nettype wire

// File: tests/tb_game_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_game_top;

    localparam int                  CLK_PERIOD      = 40;
    localparam int                  STEP_PERIOD     = 2;
    localparam int                  END_HOLD_CYCLES = 40;
    localparam game_pkg::coord_t    TARGET_X0       = 10'd0;
    localparam game_pkg::coord_t    TARGET_Y0       = 10'd100;
    localparam game_pkg::velocity_t TARGET_DX       = 4'sd1;
    localparam game_pkg::coord_t    TORPEDO_X0      = 10'd312;
    localparam game_pkg::coord_t    TORPEDO_Y0      = 10'd440;
    localparam game_pkg::velocity_t TORPEDO_DY      = -4'sd4;

    localparam int SIZE   = int'(game_pkg::SPRITE_SIZE);
    localparam int WIDTH  = int'(game_pkg::SCREEN_WIDTH);
    localparam int HEIGHT = int'(game_pkg::SCREEN_HEIGHT);

    // Torpedo steps up to the target row, and the target x at which the key must go down
    localparam int CLIMB_STEPS = (int'(TORPEDO_Y0) - int'(TARGET_Y0)) / (-int'(TORPEDO_DY));
    localparam int LAUNCH_X    = int'(TORPEDO_X0) - CLIMB_STEPS * int'(TARGET_DX) + SIZE / 2;

    // The FSM re-enters START, issues the position load and the sprites take it
    localparam int RESTART_CYCLES = 3;

    // Longest round is the target crossing the whole screen, then the hold
    localparam int ROUND_CYCLES = STEP_PERIOD * WIDTH + END_HOLD_CYCLES + 20;
    localparam int WATCHDOG_NS  = 6 * ROUND_CYCLES * CLK_PERIOD;

    logic             clk;
    logic             reset;
    logic             key;
    game_pkg::coord_t target_x;
    game_pkg::coord_t target_y;
    game_pkg::coord_t torpedo_x;
    game_pkg::coord_t torpedo_y;
    logic             game_won;
    logic             game_over;

    int               error_count;
    int               check_count;

    game_top
    #(
        .STEP_PERIOD     (STEP_PERIOD),
        .END_HOLD_CYCLES (END_HOLD_CYCLES),
        .TARGET_X0       (TARGET_X0),
        .TARGET_Y0       (TARGET_Y0),
        .TARGET_DX       (TARGET_DX),
        .TARGET_DY       (4'sd0),
        .TORPEDO_X0      (TORPEDO_X0),
        .TORPEDO_Y0      (TORPEDO_Y0),
        .TORPEDO_DY      (TORPEDO_DY)
    )
    dut0 (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Outputs are sampled at the same point where inputs change, well after the edge
    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic check_coord(input string what, input game_pkg::coord_t actual,
                               input game_pkg::coord_t expected);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("ERR %0t: %s is %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    task automatic check_flag(input string what, input logic actual, input logic expected);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("ERR %0t: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    task automatic wait_over(input logic level);
        int n;
        n = 0;
        while (game_over !== level && n < ROUND_CYCLES)
        begin
            tick();
            n++;
        end
        if (game_over !== level)
        begin
            error_count++;
            $display("Timed out at %0t waiting for game_over to become %b", $time, level);
        end
    endtask

    task automatic wait_target_x(input game_pkg::coord_t value);
        int n;
        n = 0;
        while (target_x !== value && n < ROUND_CYCLES)
        begin
            tick();
            n++;
        end
        if (target_x !== value)
        begin
            error_count++;
            $display("Timed out at %0t waiting for the target to reach x %0d", $time, value);
        end
    endtask

    task automatic press_key();
        key = 1'b1;
        tick();
        key = 1'b0;
    endtask

    // End of the hold, then the start load brings both sprites home
    task automatic wait_restart();
        wait_over(1'b0);
        repeat (RESTART_CYCLES)
            tick();
        check_coord("target_x at restart", target_x, TARGET_X0);
        check_coord("target_y at restart", target_y, TARGET_Y0);
        check_coord("torpedo_x at restart", torpedo_x, TORPEDO_X0);
        check_coord("torpedo_y at restart", torpedo_y, TORPEDO_Y0);
    endtask

    // In AIM only the target drifts, one step of TARGET_DX at a time
    task automatic observe_round_start();
        game_pkg::coord_t last_x;
        check_coord("target_x at start", target_x, TARGET_X0);
        check_coord("target_y at start", target_y, TARGET_Y0);
        check_coord("torpedo_x at start", torpedo_x, TORPEDO_X0);
        check_coord("torpedo_y at start", torpedo_y, TORPEDO_Y0);
        last_x = target_x;
        repeat (10 * STEP_PERIOD)
        begin
            tick();
            if (target_x != last_x)
                check_coord("target_x step", target_x, last_x + game_pkg::coord_t'(TARGET_DX));
            last_x = target_x;
            check_coord("target_y in aim", target_y, TARGET_Y0);
            check_coord("torpedo_x in aim", torpedo_x, TORPEDO_X0);
            check_coord("torpedo_y in aim", torpedo_y, TORPEDO_Y0);
            check_flag("game_won in aim", game_won, 1'b0);
            check_flag("game_over in aim", game_over, 1'b0);
        end
        check_flag("target has moved", target_x > TARGET_X0, 1'b1);
    endtask

    task automatic test_reset_start();
        observe_round_start();
    endtask

    task automatic test_target_escapes();
        wait_over(1'b1);
        check_flag("game_won after escape", game_won, 1'b0);
        check_flag("target on screen after escape", int'(target_x) + SIZE <= WIDTH, 1'b0);
        wait_restart();
        check_flag("game_won after escape restart", game_won, 1'b0);
    endtask

    task automatic test_hit();
        wait_target_x(game_pkg::coord_t'(LAUNCH_X));
        press_key();
        wait_over(1'b1);
        check_flag("game_won at hit", game_won, 1'b1);
        check_coord("torpedo_x after launch", torpedo_x, TORPEDO_X0);
        wait_over(1'b0);
        check_flag("game_won at end of hold", game_won, 1'b1);
        wait_restart();
    endtask

    task automatic test_miss();
        press_key();
        wait_over(1'b1);
        check_flag("game_won after miss", game_won, 1'b0);
        check_flag("torpedo off screen", int'(torpedo_y) + SIZE > HEIGHT, 1'b1);
        check_flag("target on screen after miss", int'(target_x) + SIZE <= WIDTH, 1'b1);
        wait_restart();
    endtask

    task automatic test_restart_after_win();
        game_pkg::coord_t frozen_x;
        game_pkg::coord_t frozen_y;
        int               idle;
        wait_target_x(game_pkg::coord_t'(LAUNCH_X));
        press_key();
        wait_over(1'b1);
        check_flag("game_won before idle", game_won, 1'b1);
        frozen_x = target_x;
        frozen_y = torpedo_y;
        idle = 1 + int'($urandom % 12);
        repeat (idle) tick();
        // Sprites stay frozen through the hold whatever the key does
        key = 1'b1;
        repeat (4)
        begin
            tick();
            check_flag("game_over during hold", game_over, 1'b1);
            check_coord("target_x during hold", target_x, frozen_x);
            check_coord("torpedo_y during hold", torpedo_y, frozen_y);
        end
        key = 1'b0;
        wait_restart();
        check_flag("game_won after win restart", game_won, 1'b0);
        observe_round_start();
    endtask

    initial
    begin
        clk         = 1'b0;
        reset       = 1'b1;
        key         = 1'b0;
        error_count = 0;
        check_count = 0;
        void'($urandom(22));
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;

        test_reset_start();
        test_target_escapes();
        test_hit();
        test_miss();
        test_restart_after_win();

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired at %0t before the tests finished", $time);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
source/game_pkg.sv
source/sprite_mover.sv
source/sprite_collision.sv
source/end_of_game_timer.sv
source/game_master_fsm.sv
source/game_top.sv
tests/tb_game_top.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and decide the result from the log
verilator --binary --timing --top-module tb_game_top -f list.f -o sim_game_top \
    && ./obj_dir/sim_game_top | tee sim.log \
    && grep -q "All tests passed" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
